// ==== source/decodePkg.sv ====
`default_nettype none

package decodePkg;

	localparam int OpWidth = 6;
	localparam int RegIdxWidth = 5;
	localparam int InstrWidth = 32;
	localparam int AluOpWidth = 5;
	localparam int MulDivOpWidth = 4;
	localparam int ExcCodeWidth = 5;

	// One word, two field layouts
	typedef union packed {
		struct packed {
			logic [OpWidth-1:0] op;
			logic [RegIdxWidth-1:0] rs;
			logic [RegIdxWidth-1:0] rt;
			logic [RegIdxWidth-1:0] rd;
			logic [RegIdxWidth-1:0] shamt;
			logic [OpWidth-1:0] funct;
		} r;
		struct packed {
			logic [OpWidth-1:0] op;
			logic [RegIdxWidth-1:0] rs;
			logic [RegIdxWidth-1:0] rt;
			logic [15:0] imm;
		} i;
	} instrWord_u;

	localparam logic [OpWidth-1:0] OpRtype = 6'b000000, OpRegimm = 6'b000001,
		OpSpecial2 = 6'b011100, OpJ = 6'b000010, OpJal = 6'b000011,
		OpBeq = 6'b000100, OpBne = 6'b000101, OpBlez = 6'b000110, OpBgtz = 6'b000111,
		OpBeql = 6'b010100, OpBnel = 6'b010101, OpBlezl = 6'b010110, OpBgtzl = 6'b010111,
		OpAddi = 6'b001000, OpAddiu = 6'b001001, OpSlti = 6'b001010, OpSltiu = 6'b001011,
		OpAndi = 6'b001100, OpOri = 6'b001101, OpXori = 6'b001110, OpLui = 6'b001111,
		OpLb = 6'b100000, OpLh = 6'b100001, OpLw = 6'b100011, OpLbu = 6'b100100,
		OpLhu = 6'b100101, OpSb = 6'b101000, OpSh = 6'b101001, OpSw = 6'b101011;

	localparam logic [OpWidth-1:0] FnSll = 6'b000000, FnSrl = 6'b000010, FnSra = 6'b000011,
		FnSllv = 6'b000100, FnSrlv = 6'b000110, FnSrav = 6'b000111, FnJr = 6'b001000,
		FnJalr = 6'b001001, FnSyscall = 6'b001100, FnBreak = 6'b001101, FnSync = 6'b001111,
		FnMfhi = 6'b010000, FnMthi = 6'b010001, FnMflo = 6'b010010, FnMtlo = 6'b010011,
		FnMult = 6'b011000, FnMultu = 6'b011001, FnDiv = 6'b011010, FnDivu = 6'b011011,
		FnAdd = 6'b100000, FnAddu = 6'b100001, FnSub = 6'b100010, FnSubu = 6'b100011,
		FnAnd = 6'b100100, FnOr = 6'b100101, FnXor = 6'b100110, FnNor = 6'b100111,
		FnSlt = 6'b101010, FnSltu = 6'b101011,
		FnMadd = 6'b000000, FnMaddu = 6'b000001, FnMsub = 6'b000100, FnMsubu = 6'b000101;

	localparam logic [RegIdxWidth-1:0] RtBltz = 5'b00000, RtBgez = 5'b00001,
		RtBltzl = 5'b00010, RtBgezl = 5'b00011, RtBltzal = 5'b10000, RtBgezal = 5'b10001,
		RtBltzall = 5'b10010, RtBgezall = 5'b10011;

	localparam logic [AluOpWidth-1:0] AluAdd = 5'd0, AluSub = 5'd1, AluOr = 5'd2,
		AluAnd = 5'd3, AluNor = 5'd4, AluXor = 5'd5, AluSll = 5'd6, AluSrl = 5'd7,
		AluSra = 5'd8, AluSlt = 5'd9, AluSltu = 5'd10, AluAddu = 5'd12, AluSubu = 5'd16,
		AluNone = 5'd31;

	localparam logic [MulDivOpWidth-1:0] MulDivMultu = 4'd0, MulDivMult = 4'd1,
		MulDivDivu = 4'd2, MulDivDiv = 4'd3, MulDivMaddu = 4'd4, MulDivMadd = 4'd5,
		MulDivMsub = 4'd6, MulDivMsubu = 4'd7;

	localparam logic [1:0] NpcSeq = 2'd0, NpcTaken = 2'd1, NpcTarget = 2'd2, NpcReg = 2'd3;
	localparam logic [1:0] ExtZero = 2'd0, ExtSign = 2'd1, ExtUpper = 2'd2;
	localparam logic [2:0] WbHilo = 3'd0, WbLui = 3'd1, WbAlu = 3'd2, WbLink = 3'd3,
		WbMem = 3'd4;
	localparam logic [1:0] RegDstRt = 2'd0, RegDstRd = 2'd1, RegDst31 = 2'd2;
	localparam logic [2:0] MemSizeWord = 3'b010, MemSizeByteU = 3'b011,
		MemSizeByte = 3'b100, MemSizeHalfU = 3'b101, MemSizeHalf = 3'b110;

	localparam logic [ExcCodeWidth-1:0] ExcRi = 5'd10, ExcBp = 5'd9, ExcSys = 5'd8;

	localparam logic [1:0] CmpNeg = 2'b10, CmpPos = 2'b01; // Zero is 00

endpackage

`default_nettype wire

// ==== source/datapathDecoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module datapathDecoder (
	input  decodePkg::instrWord_u instr,
	output logic regWrite,
	output logic [1:0] regDstSel,
	output logic [2:0] wbSel,
	output logic hiloWrite,
	output logic [1:0] hiloWriteSel,
	output logic hiloReadHi,
	output logic mulDivStart,
	output logic [decodePkg::AluOpWidth-1:0] aluOp,
	output logic aluShamtSel,
	output logic aluImmSel,
	output logic [decodePkg::MulDivOpWidth-1:0] mulDivOp,
	output logic [1:0] extOp,
	output logic memRead,
	output logic memWrite,
	output logic [2:0] memSize,
	output logic isBreak,
	output logic isSyscall,
	output logic dpKnown
);
	import decodePkg::*;

	always_comb begin
		regWrite = 1'b0;
		regDstSel = RegDstRt;
		wbSel = WbAlu;
		hiloWrite = 1'b0;
		hiloWriteSel = 2'b00; // MTLO path
		hiloReadHi = 1'b0;
		mulDivStart = 1'b0;
		aluOp = AluNone;
		aluShamtSel = 1'b0;
		aluImmSel = 1'b0;
		mulDivOp = MulDivMultu;
		extOp = ExtZero;
		memRead = 1'b0;
		memWrite = 1'b0;
		memSize = MemSizeWord;
		isBreak = 1'b0;
		isSyscall = 1'b0;
		dpKnown = 1'b1;
		case (instr.r.op)
			OpRtype: begin
				regDstSel = RegDstRd;
				case (instr.r.funct)
					FnAdd: aluOp = AluAdd;
					FnAddu: aluOp = AluAddu;
					FnSub: aluOp = AluSub;
					FnSubu: aluOp = AluSubu;
					FnAnd: aluOp = AluAnd;
					FnOr: aluOp = AluOr;
					FnXor: aluOp = AluXor;
					FnNor: aluOp = AluNor;
					FnSlt: aluOp = AluSlt;
					FnSltu: aluOp = AluSltu;
					FnSllv, FnSll: aluOp = AluSll;
					FnSrlv, FnSrl: aluOp = AluSrl;
					FnSrav, FnSra: aluOp = AluSra;
					default: aluOp = AluNone;
				endcase
				aluShamtSel = (instr.r.funct == FnSll) || (instr.r.funct == FnSrl) ||
					(instr.r.funct == FnSra); // Shift by shamt field
				case (instr.r.funct)
					FnMfhi, FnMflo: begin
						regWrite = 1'b1;
						wbSel = WbHilo;
						hiloReadHi = (instr.r.funct == FnMfhi);
					end
					FnMthi, FnMtlo: begin
						hiloWrite = 1'b1;
						hiloWriteSel = (instr.r.funct == FnMthi) ? 2'b01 : 2'b00;
					end
					FnMult, FnMultu, FnDiv, FnDivu: begin
						hiloWrite = 1'b1;
						hiloWriteSel = 2'b10; // Result from mul/div unit
						mulDivStart = 1'b1;
						mulDivOp = {2'b00, instr.r.funct[1], ~instr.r.funct[0]};
					end
					FnJalr: begin
						regWrite = 1'b1;
						regDstSel = RegDst31;
						wbSel = WbLink;
					end
					FnBreak: isBreak = 1'b1;
					FnSyscall: isSyscall = 1'b1;
					FnJr, FnSync: ;
					default: begin
						regWrite = (aluOp != AluNone);
						dpKnown = (aluOp != AluNone);
					end
				endcase
			end
			OpSpecial2: begin
				hiloWrite = 1'b1;
				hiloWriteSel = 2'b10;
				mulDivStart = 1'b1;
				case (instr.r.funct)
					FnMaddu: mulDivOp = MulDivMaddu;
					FnMadd: mulDivOp = MulDivMadd;
					FnMsub: mulDivOp = MulDivMsub;
					FnMsubu: mulDivOp = MulDivMsubu;
					default: begin
						hiloWrite = 1'b0;
						mulDivStart = 1'b0;
						dpKnown = 1'b0;
					end
				endcase
			end
			OpAddi, OpAddiu, OpSlti, OpSltiu, OpAndi, OpOri, OpXori, OpLui: begin
				regWrite = 1'b1;
				aluImmSel = 1'b1;
				extOp = instr.i.op[2] ? ExtZero : ExtSign; // Logical ops zero-extend
				case (instr.i.op)
					OpAddi: aluOp = AluAdd;
					OpAddiu: aluOp = AluAddu;
					OpSlti: aluOp = AluSlt;
					OpSltiu: aluOp = AluSltu;
					OpAndi: aluOp = AluAnd;
					OpOri: aluOp = AluOr;
					OpXori: aluOp = AluXor;
					default: begin
						extOp = ExtUpper; // LUI
						wbSel = WbLui;
					end
				endcase
			end
			OpLb, OpLbu, OpLh, OpLhu, OpLw, OpSb, OpSh, OpSw: begin
				aluOp = AluAdd; // Address calc
				aluImmSel = 1'b1;
				extOp = ExtSign;
				memWrite = instr.i.op[3];
				memRead = ~instr.i.op[3];
				regWrite = ~instr.i.op[3];
				wbSel = WbMem;
				case (instr.i.op)
					OpLb, OpSb: memSize = MemSizeByte;
					OpLbu: memSize = MemSizeByteU;
					OpLh, OpSh: memSize = MemSizeHalf;
					OpLhu: memSize = MemSizeHalfU;
					default: memSize = MemSizeWord;
				endcase
			end
			OpJal: begin
				regWrite = 1'b1;
				regDstSel = RegDst31;
				wbSel = WbLink;
			end
			OpRegimm: begin
				// Linking forms have rt[4] set
				if (instr.i.rt[4] && (instr.i.rt[3:2] == 2'b00)) begin
					regWrite = 1'b1;
					regDstSel = RegDst31;
					wbSel = WbLink;
				end
				dpKnown = 1'b0;
			end
			default: dpKnown = 1'b0;
		endcase
	end

endmodule

`default_nettype wire

// ==== source/branchDecoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module branchDecoder (
	input  decodePkg::instrWord_u instr,
	input  logic cmpEqual,
	input  logic [1:0] cmpSign,
	output logic [1:0] npcOp,
	output logic isBranch,
	output logic branchFlush,
	output logic jump,
	output logic brKnown
);
	import decodePkg::*;

	logic taken;
	logic likely;

	always_comb begin
		taken = 1'b0;
		likely = 1'b0;
		isBranch = 1'b1;
		case (instr.i.op)
			OpBeq, OpBeql: taken = cmpEqual;
			OpBne, OpBnel: taken = ~cmpEqual;
			OpBlez, OpBlezl: begin
				taken = (cmpSign != CmpPos);
				isBranch = (instr.i.rt == '0);
			end
			OpBgtz, OpBgtzl: begin
				taken = (cmpSign == CmpPos);
				isBranch = (instr.i.rt == '0);
			end
			OpRegimm: begin
				case (instr.i.rt)
					RtBltz, RtBltzl, RtBltzal, RtBltzall: taken = (cmpSign == CmpNeg);
					RtBgez, RtBgezl, RtBgezal, RtBgezall: taken = (cmpSign != CmpNeg);
					default: isBranch = 1'b0;
				endcase
				likely = instr.i.rt[1]; // L forms
			end
			default: isBranch = 1'b0;
		endcase
		if (instr.i.op[4])
			likely = 1'b1; // BEQL..BGTZL opcodes
		taken = taken & isBranch;
		likely = likely & isBranch;
	end

	always_comb begin
		brKnown = isBranch;
		if (taken)
			npcOp = NpcTaken;
		else
			npcOp = NpcSeq;
		if ((instr.i.op == OpJ) || (instr.i.op == OpJal)) begin
			npcOp = NpcTarget;
			brKnown = 1'b1;
		end else if ((instr.r.op == OpRtype) &&
			((instr.r.funct == FnJr) || (instr.r.funct == FnJalr))) begin
			npcOp = NpcReg;
			brKnown = 1'b1;
		end
	end

	assign branchFlush = likely & ~taken; // Squash delay slot
	assign jump = (npcOp != NpcSeq);

endmodule

`default_nettype wire

// ==== source/controlMerge.sv ====
`timescale 1ns/1ps
`default_nettype none

module controlMerge (
	input  logic clk,
	input  logic rst,
	input  logic instrValid,
	input  logic fetchException,
	input  logic [decodePkg::ExcCodeWidth-1:0] fetchExcCode,
	input  logic ifFlush,
	input  logic decRegWrite,
	input  logic [1:0] decRegDstSel,
	input  logic [2:0] decWbSel,
	input  logic decHiloWrite,
	input  logic [1:0] decHiloWriteSel,
	input  logic decHiloReadHi,
	input  logic decMulDivStart,
	input  logic [decodePkg::AluOpWidth-1:0] decAluOp,
	input  logic decAluShamtSel,
	input  logic decAluImmSel,
	input  logic [decodePkg::MulDivOpWidth-1:0] decMulDivOp,
	input  logic [1:0] decExtOp,
	input  logic decMemRead,
	input  logic decMemWrite,
	input  logic [2:0] decMemSize,
	input  logic isBreak,
	input  logic isSyscall,
	input  logic dpKnown,
	input  logic [1:0] decNpcOp,
	input  logic decIsBranch,
	input  logic decBranchFlush,
	input  logic decJump,
	input  logic brKnown,
	output logic ctrlValid,
	output logic exception,
	output logic [decodePkg::ExcCodeWidth-1:0] excCode,
	output logic regWrite,
	output logic [1:0] regDstSel,
	output logic [2:0] wbSel,
	output logic hiloWrite,
	output logic [1:0] hiloWriteSel,
	output logic hiloReadHi,
	output logic mulDivStart,
	output logic [decodePkg::AluOpWidth-1:0] aluOp,
	output logic aluShamtSel,
	output logic aluImmSel,
	output logic [decodePkg::MulDivOpWidth-1:0] mulDivOp,
	output logic [1:0] extOp,
	output logic memRead,
	output logic memWrite,
	output logic [2:0] memSize,
	output logic [1:0] npcOp,
	output logic isBranch,
	output logic branchFlush,
	output logic jump
);
	import decodePkg::*;

	logic ri;
	logic excNext;
	logic [ExcCodeWidth-1:0] excCodeNext;

	assign ri = ~dpKnown & ~brKnown; // Neither decoder claims it

	always_comb begin
		excNext = 1'b1;
		excCodeNext = '0;
		if (fetchException)
			excCodeNext = fetchExcCode;
		else if (ri && !ifFlush)
			excCodeNext = ExcRi;
		else if (isBreak)
			excCodeNext = ExcBp;
		else if (isSyscall)
			excCodeNext = ExcSys;
		else
			excNext = 1'b0;
	end

	always_ff @(posedge clk) begin
		if (!rst) begin
			ctrlValid <= 1'b0;
			exception <= 1'b0;
			regWrite <= 1'b0;
			hiloWrite <= 1'b0;
			mulDivStart <= 1'b0;
			memRead <= 1'b0;
			memWrite <= 1'b0;
			npcOp <= NpcSeq;
			isBranch <= 1'b0;
			branchFlush <= 1'b0;
			jump <= 1'b0;
		end else begin
			ctrlValid <= instrValid;
			exception <= excNext & instrValid;
			regWrite <= decRegWrite & instrValid;
			hiloWrite <= decHiloWrite & instrValid;
			mulDivStart <= decMulDivStart & instrValid;
			memRead <= decMemRead & instrValid;
			memWrite <= decMemWrite & instrValid;
			npcOp <= instrValid ? decNpcOp : NpcSeq;
			isBranch <= decIsBranch & instrValid;
			branchFlush <= decBranchFlush & instrValid;
			jump <= decJump & instrValid;
		end
	end

	// Payload fields, meaningful only with ctrlValid
	always_ff @(posedge clk) begin
		excCode <= excCodeNext;
		regDstSel <= decRegDstSel;
		wbSel <= decWbSel;
		hiloWriteSel <= decHiloWriteSel;
		hiloReadHi <= decHiloReadHi;
		aluOp <= decAluOp;
		aluShamtSel <= decAluShamtSel;
		aluImmSel <= decAluImmSel;
		mulDivOp <= decMulDivOp;
		extOp <= decExtOp;
		memSize <= decMemSize;
	end

endmodule

`default_nettype wire

// ==== source/controlUnit.sv ====
`timescale 1ns/1ps
`default_nettype none

module controlUnit (
	input  logic clk,
	input  logic rst,
	input  logic instrValid,
	input  decodePkg::instrWord_u instr,
	input  logic cmpEqual,
	input  logic [1:0] cmpSign,
	input  logic fetchException,
	input  logic [decodePkg::ExcCodeWidth-1:0] fetchExcCode,
	input  logic ifFlush,
	output logic ctrlValid,
	output logic exception,
	output logic [decodePkg::ExcCodeWidth-1:0] excCode,
	output logic regWrite,
	output logic [1:0] regDstSel,
	output logic [2:0] wbSel,
	output logic hiloWrite,
	output logic [1:0] hiloWriteSel,
	output logic hiloReadHi,
	output logic mulDivStart,
	output logic [decodePkg::AluOpWidth-1:0] aluOp,
	output logic aluShamtSel,
	output logic aluImmSel,
	output logic [decodePkg::MulDivOpWidth-1:0] mulDivOp,
	output logic [1:0] extOp,
	output logic memRead,
	output logic memWrite,
	output logic [2:0] memSize,
	output logic [1:0] npcOp,
	output logic isBranch,
	output logic branchFlush,
	output logic jump
);
	import decodePkg::*;

	logic dRegWrite, dHiloWrite, dHiloReadHi, dMulDivStart, dAluShamtSel, dAluImmSel;
	logic dMemRead, dMemWrite, isBreak, isSyscall, dpKnown;
	logic [1:0] dRegDstSel, dHiloWriteSel, dExtOp, bNpcOp;
	logic [2:0] dWbSel, dMemSize;
	logic [AluOpWidth-1:0] dAluOp;
	logic [MulDivOpWidth-1:0] dMulDivOp;
	logic bIsBranch, bBranchFlush, bJump, brKnown;

	datapathDecoder datapathDecoder_inst (
		.instr(instr), .regWrite(dRegWrite), .regDstSel(dRegDstSel), .wbSel(dWbSel),
		.hiloWrite(dHiloWrite), .hiloWriteSel(dHiloWriteSel), .hiloReadHi(dHiloReadHi),
		.mulDivStart(dMulDivStart), .aluOp(dAluOp), .aluShamtSel(dAluShamtSel),
		.aluImmSel(dAluImmSel), .mulDivOp(dMulDivOp), .extOp(dExtOp),
		.memRead(dMemRead), .memWrite(dMemWrite), .memSize(dMemSize),
		.isBreak(isBreak), .isSyscall(isSyscall), .dpKnown(dpKnown)
	);

	branchDecoder branchDecoder_inst (
		.instr(instr), .cmpEqual(cmpEqual), .cmpSign(cmpSign), .npcOp(bNpcOp),
		.isBranch(bIsBranch), .branchFlush(bBranchFlush), .jump(bJump), .brKnown(brKnown)
	);

	controlMerge controlMerge_inst (
		.clk(clk), .rst(rst), .instrValid(instrValid), .fetchException(fetchException),
		.fetchExcCode(fetchExcCode), .ifFlush(ifFlush),
		.decRegWrite(dRegWrite), .decRegDstSel(dRegDstSel), .decWbSel(dWbSel),
		.decHiloWrite(dHiloWrite), .decHiloWriteSel(dHiloWriteSel),
		.decHiloReadHi(dHiloReadHi), .decMulDivStart(dMulDivStart), .decAluOp(dAluOp),
		.decAluShamtSel(dAluShamtSel), .decAluImmSel(dAluImmSel), .decMulDivOp(dMulDivOp),
		.decExtOp(dExtOp), .decMemRead(dMemRead), .decMemWrite(dMemWrite),
		.decMemSize(dMemSize), .isBreak(isBreak), .isSyscall(isSyscall), .dpKnown(dpKnown),
		.decNpcOp(bNpcOp), .decIsBranch(bIsBranch), .decBranchFlush(bBranchFlush),
		.decJump(bJump), .brKnown(brKnown),
		.ctrlValid(ctrlValid), .exception(exception), .excCode(excCode),
		.regWrite(regWrite), .regDstSel(regDstSel), .wbSel(wbSel), .hiloWrite(hiloWrite),
		.hiloWriteSel(hiloWriteSel), .hiloReadHi(hiloReadHi), .mulDivStart(mulDivStart),
		.aluOp(aluOp), .aluShamtSel(aluShamtSel), .aluImmSel(aluImmSel),
		.mulDivOp(mulDivOp), .extOp(extOp), .memRead(memRead), .memWrite(memWrite),
		.memSize(memSize), .npcOp(npcOp), .isBranch(isBranch), .branchFlush(branchFlush),
		.jump(jump)
	);

endmodule

`default_nettype wire

// ==== testbench/controlUnit_sva.sv ====
`timescale 1ns/1ps
`default_nettype none

module controlUnitSva (
	input logic clk,
	input logic rst,
	input logic ctrlValid,
	input logic regWrite,
	input logic hiloWrite,
	input logic mulDivStart,
	input logic memRead,
	input logic memWrite,
	input logic jump,
	input logic branchFlush,
	input logic exception,
	input logic [1:0] npcOp
);
	import decodePkg::*;

	int failCount = 0; // Assertion failures so far

	// No enable may fire without a valid control word
	assert property (@(posedge clk) disable iff (!rst)
		!ctrlValid |-> !(regWrite || hiloWrite || mulDivStart || memRead || memWrite ||
			jump || branchFlush || exception))
		else begin
			failCount = failCount + 1;
			$error("enable high while ctrlValid is low");
		end

	assert property (@(posedge clk) disable iff (!rst) !(memRead && memWrite))
		else begin
			failCount = failCount + 1;
			$error("memRead and memWrite both high");
		end

	assert property (@(posedge clk) disable iff (!rst) jump == (npcOp != NpcSeq))
		else begin
			failCount = failCount + 1;
			$error("jump disagrees with npcOp");
		end

endmodule

bind controlUnit controlUnitSva controlUnitSva_inst (
	.clk(clk), .rst(rst), .ctrlValid(ctrlValid), .regWrite(regWrite),
	.hiloWrite(hiloWrite), .mulDivStart(mulDivStart), .memRead(memRead),
	.memWrite(memWrite), .jump(jump), .branchFlush(branchFlush),
	.exception(exception), .npcOp(npcOp)
);

`default_nettype wire

// ==== testbench/controlUnitTb.sv ====
`timescale 1ns/1ps
`default_nettype none

module controlUnitTb;
	import decodePkg::*;

	localparam int NumTests = 200; // Upper bound on issued instructions
	localparam int ClkPeriod = 8;
	localparam logic [ExcCodeWidth-1:0] FetchCode = 5'd4; // Address error on fetch
	localparam logic [OpWidth-1:0] OpUnused = 6'b111011;

	logic clk = 1'b0;
	logic rst;
	logic instrValid;
	instrWord_u instr;
	logic cmpEqual;
	logic [1:0] cmpSign;
	logic fetchException;
	logic [ExcCodeWidth-1:0] fetchExcCode;
	logic ifFlush;
	logic ctrlValid, exception, regWrite, hiloWrite, hiloReadHi, mulDivStart;
	logic aluShamtSel, aluImmSel, memRead, memWrite, isBranch, branchFlush, jump;
	logic [ExcCodeWidth-1:0] excCode;
	logic [1:0] regDstSel, hiloWriteSel, extOp, npcOp;
	logic [2:0] wbSel, memSize;
	logic [AluOpWidth-1:0] aluOp;
	logic [MulDivOpWidth-1:0] mulDivOp;
	integer seed = 32'h35fd;

	controlUnit controlUnit_inst (.*);

	always #(ClkPeriod / 2) clk = ~clk;

	task automatic reportMismatch(input string msg);
		$display("mismatch at %0t ns: %s", $time, msg);
		$display("ERRORS FOUND");
		$fatal(1, "check failed");
	endtask

	task automatic checkFlag(input logic got, input logic exp, input string what);
		if (got !== exp)
			reportMismatch($sformatf("%s got %b expected %b", what, got, exp));
	endtask

	task automatic checkAluOp(input logic [AluOpWidth-1:0] got,
		input logic [AluOpWidth-1:0] exp, input string what);
		if (got !== exp)
			reportMismatch($sformatf("%s got %0d expected %0d", what, got, exp));
	endtask

	task automatic checkMulDivOp(input logic [MulDivOpWidth-1:0] got,
		input logic [MulDivOpWidth-1:0] exp, input string what);
		if (got !== exp)
			reportMismatch($sformatf("%s got %0d expected %0d", what, got, exp));
	endtask

	task automatic checkNpcOp(input logic [1:0] got, input logic [1:0] exp, input string what);
		if (got !== exp)
			reportMismatch($sformatf("%s got %0d expected %0d", what, got, exp));
	endtask

	task automatic checkExcCode(input logic [ExcCodeWidth-1:0] got,
		input logic [ExcCodeWidth-1:0] exp, input string what);
		if (got !== exp)
			reportMismatch($sformatf("%s got %0d expected %0d", what, got, exp));
	endtask

	task automatic checkSel(input logic [2:0] got, input logic [2:0] exp, input string what);
		if (got !== exp)
			reportMismatch($sformatf("%s got %0d expected %0d", what, got, exp));
	endtask

	function automatic logic [RegIdxWidth-1:0] randField();
		int r;
		r = $random(seed);
		return r[RegIdxWidth-1:0];
	endfunction

	function automatic instrWord_u rWord(input logic [OpWidth-1:0] op,
		input logic [OpWidth-1:0] funct);
		instrWord_u w;
		w.r.op = op;
		w.r.rs = randField();
		w.r.rt = randField();
		w.r.rd = randField();
		w.r.shamt = randField();
		w.r.funct = funct;
		return w;
	endfunction

	function automatic instrWord_u iWord(input logic [OpWidth-1:0] op,
		input logic [RegIdxWidth-1:0] rt);
		instrWord_u w;
		w.i.op = op;
		w.i.rs = randField();
		w.i.rt = rt;
		w.i.imm = {randField(), randField(), randField(), 1'b0};
		return w;
	endfunction

	// Branch conditions as defined for each instruction
	function automatic logic branchTaken(input logic [OpWidth-1:0] op,
		input logic [RegIdxWidth-1:0] rt, input logic eq, input logic [1:0] sign);
		logic neg;
		logic pos;
		neg = (sign == CmpNeg);
		pos = (sign == CmpPos);
		case (op)
			OpBeq, OpBeql: return eq;
			OpBne, OpBnel: return !eq;
			OpBlez, OpBlezl: return !pos;
			OpBgtz, OpBgtzl: return pos;
			default: begin
				if (rt == RtBgez || rt == RtBgezl || rt == RtBgezal || rt == RtBgezall)
					return !neg;
				return neg;
			end
		endcase
	endfunction

	// Drives one instruction, then idles so its control word stands alone
	task automatic issue(input instrWord_u w, input logic eq, input logic [1:0] sign,
		input logic fetchExc, input logic flush);
		@(posedge clk);
		instrValid <= 1'b1;
		instr <= w;
		cmpEqual <= eq;
		cmpSign <= sign;
		fetchException <= fetchExc;
		ifFlush <= flush;
		@(posedge clk);
		instrValid <= 1'b0;
		fetchException <= 1'b0;
		ifFlush <= 1'b0;
		@(negedge clk);
		checkFlag(ctrlValid, 1'b1, "ctrlValid one cycle after issue");
	endtask

	task automatic aluRtype(input logic [OpWidth-1:0] funct, input logic [AluOpWidth-1:0] expOp,
		input logic byShamt);
		issue(rWord(OpRtype, funct), 1'b0, 2'b00, 1'b0, 1'b0);
		checkAluOp(aluOp, expOp, "R-type aluOp");
		checkFlag(aluShamtSel, byShamt, "R-type aluShamtSel");
		checkFlag(aluImmSel, 1'b0, "R-type aluImmSel");
		checkSel({1'b0, regDstSel}, {1'b0, RegDstRd}, "R-type regDstSel");
		checkSel(wbSel, WbAlu, "R-type wbSel");
		checkFlag(regWrite, 1'b1, "R-type regWrite");
		checkFlag(exception, 1'b0, "R-type exception");
	endtask

	task automatic aluImm(input logic [OpWidth-1:0] op, input logic [AluOpWidth-1:0] expOp,
		input logic [1:0] expExt, input logic [2:0] expWb);
		issue(iWord(op, randField()), 1'b0, 2'b00, 1'b0, 1'b0);
		checkAluOp(aluOp, expOp, "immediate aluOp");
		checkSel({1'b0, extOp}, {1'b0, expExt}, "immediate extOp");
		checkFlag(aluImmSel, 1'b1, "immediate aluImmSel");
		checkFlag(aluShamtSel, 1'b0, "immediate aluShamtSel");
		checkSel({1'b0, regDstSel}, {1'b0, RegDstRt}, "immediate regDstSel");
		checkSel(wbSel, expWb, "immediate wbSel");
		checkFlag(regWrite, 1'b1, "immediate regWrite");
	endtask

	task automatic testAlu();
		aluRtype(FnAdd, AluAdd, 1'b0);
		aluRtype(FnAddu, AluAddu, 1'b0);
		aluRtype(FnSub, AluSub, 1'b0);
		aluRtype(FnSubu, AluSubu, 1'b0);
		aluRtype(FnAnd, AluAnd, 1'b0);
		aluRtype(FnOr, AluOr, 1'b0);
		aluRtype(FnXor, AluXor, 1'b0);
		aluRtype(FnNor, AluNor, 1'b0);
		aluRtype(FnSlt, AluSlt, 1'b0);
		aluRtype(FnSltu, AluSltu, 1'b0);
		aluRtype(FnSll, AluSll, 1'b1);
		aluRtype(FnSrl, AluSrl, 1'b1);
		aluRtype(FnSra, AluSra, 1'b1);
		aluRtype(FnSllv, AluSll, 1'b0);
		aluRtype(FnSrlv, AluSrl, 1'b0);
		aluRtype(FnSrav, AluSra, 1'b0);
		aluImm(OpAddi, AluAdd, ExtSign, WbAlu);
		aluImm(OpAddiu, AluAddu, ExtSign, WbAlu);
		aluImm(OpSlti, AluSlt, ExtSign, WbAlu);
		aluImm(OpSltiu, AluSltu, ExtSign, WbAlu);
		aluImm(OpAndi, AluAnd, ExtZero, WbAlu); // Logical immediates zero-extend
		aluImm(OpOri, AluOr, ExtZero, WbAlu);
		aluImm(OpXori, AluXor, ExtZero, WbAlu);
		aluImm(OpLui, AluNone, ExtUpper, WbLui);
	endtask

	task automatic memOp(input logic [OpWidth-1:0] op, input logic [2:0] expSize,
		input logic isStore);
		issue(iWord(op, randField()), 1'b0, 2'b00, 1'b0, 1'b0);
		checkSel(memSize, expSize, "memSize");
		checkFlag(memRead, !isStore, "memRead");
		checkFlag(memWrite, isStore, "memWrite");
		checkSel({1'b0, extOp}, {1'b0, ExtSign}, "memory extOp");
		checkFlag(aluImmSel, 1'b1, "memory aluImmSel");
		checkFlag(regWrite, !isStore, "memory regWrite");
		if (!isStore)
			checkSel(wbSel, WbMem, "load wbSel");
	endtask

	task automatic testMemory();
		memOp(OpLb, MemSizeByte, 1'b0);
		memOp(OpLbu, MemSizeByteU, 1'b0);
		memOp(OpLh, MemSizeHalf, 1'b0);
		memOp(OpLhu, MemSizeHalfU, 1'b0);
		memOp(OpLw, MemSizeWord, 1'b0);
		memOp(OpSb, MemSizeByte, 1'b1);
		memOp(OpSh, MemSizeHalf, 1'b1);
		memOp(OpSw, MemSizeWord, 1'b1);
	endtask

	task automatic mulDivCase(input logic [OpWidth-1:0] op, input logic [OpWidth-1:0] funct,
		input logic [MulDivOpWidth-1:0] expOp);
		issue(rWord(op, funct), 1'b0, 2'b00, 1'b0, 1'b0);
		checkFlag(mulDivStart, 1'b1, "mulDivStart");
		checkMulDivOp(mulDivOp, expOp, "mulDivOp");
		checkFlag(hiloWrite, 1'b1, "mul/div hiloWrite");
		checkFlag(regWrite, 1'b0, "mul/div regWrite");
	endtask

	task automatic hiloMove(input logic [OpWidth-1:0] funct, input logic toHi);
		issue(rWord(OpRtype, funct), 1'b0, 2'b00, 1'b0, 1'b0);
		checkFlag(hiloWrite, 1'b1, "move-to hiloWrite");
		checkSel({1'b0, hiloWriteSel}, {2'b00, toHi}, "hiloWriteSel"); // HI is select 1
		checkFlag(mulDivStart, 1'b0, "move-to mulDivStart");
		checkFlag(regWrite, 1'b0, "move-to regWrite");
	endtask

	task automatic hiloRead(input logic [OpWidth-1:0] funct, input logic fromHi);
		issue(rWord(OpRtype, funct), 1'b0, 2'b00, 1'b0, 1'b0);
		checkFlag(hiloReadHi, fromHi, "hiloReadHi");
		checkSel(wbSel, WbHilo, "move-from wbSel");
		checkFlag(regWrite, 1'b1, "move-from regWrite");
		checkFlag(hiloWrite, 1'b0, "move-from hiloWrite");
	endtask

	task automatic testMulDiv();
		mulDivCase(OpRtype, FnMult, MulDivMult);
		mulDivCase(OpRtype, FnMultu, MulDivMultu);
		mulDivCase(OpRtype, FnDiv, MulDivDiv);
		mulDivCase(OpRtype, FnDivu, MulDivDivu);
		mulDivCase(OpSpecial2, FnMadd, MulDivMadd);
		mulDivCase(OpSpecial2, FnMaddu, MulDivMaddu);
		mulDivCase(OpSpecial2, FnMsub, MulDivMsub);
		mulDivCase(OpSpecial2, FnMsubu, MulDivMsubu);
		hiloMove(FnMthi, 1'b1);
		hiloMove(FnMtlo, 1'b0);
		hiloRead(FnMfhi, 1'b1);
		hiloRead(FnMflo, 1'b0);
	endtask

	// Every compare outcome for one branch
	task automatic branchCase(input logic [OpWidth-1:0] op, input logic [RegIdxWidth-1:0] rt,
		input logic likelyForm, input logic links);
		logic taken;
		for (int e = 0; e < 2; e++) begin
			for (int s = 0; s < 4; s++) begin
				taken = branchTaken(op, rt, e[0], s[1:0]);
				issue(iWord(op, rt), e[0], s[1:0], 1'b0, 1'b0);
				checkNpcOp(npcOp, taken ? NpcTaken : NpcSeq, "branch npcOp");
				checkFlag(jump, taken, "branch jump");
				checkFlag(isBranch, 1'b1, "isBranch");
				checkFlag(branchFlush, likelyForm && !taken, "branchFlush");
				checkFlag(regWrite, links, "branch regWrite");
				if (links)
					checkSel({1'b0, regDstSel}, {1'b0, RegDst31}, "link regDstSel");
				checkFlag(exception, 1'b0, "branch exception");
			end
		end
	endtask

	task automatic jumpCase(input instrWord_u w, input logic [1:0] expNpc, input logic links);
		issue(w, 1'b0, 2'b00, 1'b0, 1'b0);
		checkNpcOp(npcOp, expNpc, "jump npcOp");
		checkFlag(jump, 1'b1, "jump");
		checkFlag(regWrite, links, "jump regWrite");
		if (links) begin
			checkSel(wbSel, WbLink, "jump wbSel");
			checkSel({1'b0, regDstSel}, {1'b0, RegDst31}, "jump regDstSel");
		end
	endtask

	task automatic testBranches();
		branchCase(OpBeq, randField(), 1'b0, 1'b0);
		branchCase(OpBne, randField(), 1'b0, 1'b0);
		branchCase(OpBlez, '0, 1'b0, 1'b0);
		branchCase(OpBgtz, '0, 1'b0, 1'b0);
		branchCase(OpBeql, randField(), 1'b1, 1'b0);
		branchCase(OpBnel, randField(), 1'b1, 1'b0);
		branchCase(OpBlezl, '0, 1'b1, 1'b0);
		branchCase(OpBgtzl, '0, 1'b1, 1'b0);
		branchCase(OpRegimm, RtBltz, 1'b0, 1'b0);
		branchCase(OpRegimm, RtBgez, 1'b0, 1'b0);
		branchCase(OpRegimm, RtBltzl, 1'b1, 1'b0);
		branchCase(OpRegimm, RtBgezl, 1'b1, 1'b0);
		branchCase(OpRegimm, RtBltzal, 1'b0, 1'b1);
		branchCase(OpRegimm, RtBgezal, 1'b0, 1'b1);
		branchCase(OpRegimm, RtBltzall, 1'b1, 1'b1);
		branchCase(OpRegimm, RtBgezall, 1'b1, 1'b1);
		jumpCase(iWord(OpJ, randField()), NpcTarget, 1'b0);
		jumpCase(iWord(OpJal, randField()), NpcTarget, 1'b1);
		jumpCase(rWord(OpRtype, FnJr), NpcReg, 1'b0);
		jumpCase(rWord(OpRtype, FnJalr), NpcReg, 1'b1);
	endtask

	task automatic testExceptions();
		issue(iWord(OpUnused, randField()), 1'b0, 2'b00, 1'b0, 1'b0);
		checkFlag(exception, 1'b1, "unknown opcode exception");
		checkExcCode(excCode, ExcRi, "unknown opcode excCode");
		issue(rWord(OpRtype, 6'b111111), 1'b0, 2'b00, 1'b0, 1'b0);
		checkFlag(exception, 1'b1, "unknown funct exception");
		checkExcCode(excCode, ExcRi, "unknown funct excCode");
		issue(iWord(OpUnused, randField()), 1'b0, 2'b00, 1'b0, 1'b1);
		checkFlag(exception, 1'b0, "flushed unknown opcode exception");
		issue(rWord(OpRtype, FnBreak), 1'b0, 2'b00, 1'b0, 1'b0);
		checkFlag(exception, 1'b1, "BREAK exception");
		checkExcCode(excCode, ExcBp, "BREAK excCode");
		issue(rWord(OpRtype, FnSyscall), 1'b0, 2'b00, 1'b0, 1'b0);
		checkFlag(exception, 1'b1, "SYSCALL exception");
		checkExcCode(excCode, ExcSys, "SYSCALL excCode");
		issue(rWord(OpRtype, FnBreak), 1'b0, 2'b00, 1'b1, 1'b0);
		checkFlag(exception, 1'b1, "fetch exception over BREAK");
		checkExcCode(excCode, FetchCode, "fetch excCode over BREAK");
		issue(iWord(OpUnused, randField()), 1'b0, 2'b00, 1'b1, 1'b0);
		checkFlag(exception, 1'b1, "fetch exception over RI");
		checkExcCode(excCode, FetchCode, "fetch excCode over RI");
	endtask

	task automatic testResetState();
		checkFlag(ctrlValid, 1'b0, "ctrlValid after reset");
		checkFlag(regWrite, 1'b0, "regWrite after reset");
		checkFlag(hiloWrite, 1'b0, "hiloWrite after reset");
		checkFlag(mulDivStart, 1'b0, "mulDivStart after reset");
		checkFlag(memRead, 1'b0, "memRead after reset");
		checkFlag(memWrite, 1'b0, "memWrite after reset");
		checkFlag(jump, 1'b0, "jump after reset");
		checkFlag(branchFlush, 1'b0, "branchFlush after reset");
		checkFlag(exception, 1'b0, "exception after reset");
	endtask

	// Two instructions on consecutive edges, then an idle cycle
	task automatic testBackToBack();
		instrWord_u first;
		instrWord_u second;
		first = rWord(OpRtype, FnSub);
		second = iWord(OpSw, randField());
		@(posedge clk);
		instrValid <= 1'b1;
		instr <= first;
		@(posedge clk);
		instr <= second;
		@(negedge clk);
		checkFlag(ctrlValid, 1'b1, "first ctrlValid");
		checkAluOp(aluOp, AluSub, "first aluOp");
		checkFlag(memWrite, 1'b0, "first memWrite");
		@(posedge clk);
		instrValid <= 1'b0;
		@(negedge clk);
		checkFlag(ctrlValid, 1'b1, "second ctrlValid");
		checkAluOp(aluOp, AluAdd, "second aluOp");
		checkFlag(memWrite, 1'b1, "second memWrite");
		@(negedge clk);
		checkFlag(ctrlValid, 1'b0, "idle ctrlValid");
		checkFlag(memWrite, 1'b0, "idle memWrite"); // Same word held, enables gated
	endtask

	initial begin
		rst = 1'b0;
		instrValid = 1'b0;
		instr = '0;
		cmpEqual = 1'b0;
		cmpSign = 2'b00;
		fetchException = 1'b0;
		fetchExcCode = FetchCode;
		ifFlush = 1'b0;
		repeat (3) @(posedge clk);
		rst <= 1'b1;
		@(negedge clk);
		testResetState();
		testAlu();
		testMemory();
		testMulDiv();
		testBranches();
		testExceptions();
		testBackToBack();
		if (controlUnit_inst.controlUnitSva_inst.failCount != 0) begin
			$display("a bound assertion failed during the run");
			$display("ERRORS FOUND");
			$fatal(1, "assertion failure");
		end else begin
			$display("NO ERRORS");
			$finish;
		end
	end

	initial begin
		#(ClkPeriod * (NumTests * 10 + 50));
		$display("timeout: the tests did not finish in the allowed time");
		$display("ERRORS FOUND");
		$fatal(1, "watchdog expired");
	end

endmodule

`default_nettype wire

// ==== flist.f ====
source/decodePkg.sv
source/datapathDecoder.sv
source/branchDecoder.sv
source/controlMerge.sv
source/controlUnit.sv
testbench/controlUnit_sva.sv
testbench/controlUnitTb.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = controlUnitTb
FLIST     = flist.f
OBJDIR    = obj_dir
BIN       = $(OBJDIR)/V$(TOP)
SRCS      = $(wildcard source/*.sv testbench/*.sv)

.PHONY: all run clean

all: $(BIN)

# Rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJDIR) -f $(FLIST)

run: $(BIN)
	./$(BIN)

clean:
	rm -rf $(OBJDIR)
